/* Bender.yml */
package:
  name: dispatch_stage

sources:
  - rv_isa_pkg.sv
  - frontend_pkg.sv
  - instr_decoder.sv
  - branch_predictor.sv
  - dispatch_stage.sv
  - target: test
    files:
      - tb_dispatch_stage.sv

/* branch_predictor.sv */
`timescale 1ns/1ps

module branch_predictor (
	input  logic                                 clock,
	input  logic                                 reset,
	input  logic [rv_isa_pkg::xlen-1:0]          pc,
	input  logic [31:0]                          inst,
	input  logic                                 is_branch,
	input  logic                                 is_jump,
	input  logic                                 resolve_valid,
	input  logic                                 resolve_is_branch,
	input  logic                                 resolve_taken,
	input  logic [frontend_pkg::bht_idx_width-1:0] resolve_tag,
	output logic                                 predict_taken,
	output logic [rv_isa_pkg::xlen-1:0]          predict_target,
	output logic [frontend_pkg::bht_idx_width-1:0] dirp_tag
);

	// one 2-bit saturating counter per entry
	logic [frontend_pkg::counter_width-1:0] counters [frontend_pkg::bht_entries];

	logic [frontend_pkg::counter_width-1:0] cur_count;
	logic [frontend_pkg::counter_width-1:0] res_count;
	logic                                   dir_taken;
	logic [rv_isa_pkg::xlen-1:0]            b_imm;
	logic [rv_isa_pkg::xlen-1:0]            j_imm;
	logic [rv_isa_pkg::xlen-1:0]            pc_plus_4;

	////////////////////////////////////////
	// lookup
	////////////////////////////////////////

	// indexed by pc bits 7..2, no tag match
	assign dirp_tag  = pc[frontend_pkg::bht_idx_lsb +: frontend_pkg::bht_idx_width];
	assign cur_count = counters[dirp_tag];

	// counter 2 or 3 means taken
	assign dir_taken = cur_count[frontend_pkg::counter_width-1];

	// sign extended b and j immediates
	assign b_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign j_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	assign pc_plus_4 = pc + 32'd4;

	// jal always taken, jalr left to pc+4
	assign predict_taken = is_jump || (is_branch && dir_taken);

	always_comb begin
		if (is_jump)
			predict_target = pc + j_imm;
		else if (is_branch && dir_taken)
			predict_target = pc + b_imm;
		else
			predict_target = pc_plus_4;
	end

	////////////////////////////////////////
	// resolution update
	////////////////////////////////////////

	assign res_count = counters[resolve_tag];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < frontend_pkg::bht_entries; i++)
				counters[i] <= frontend_pkg::counter_reset;
		end else if (resolve_valid && resolve_is_branch) begin
			// saturate at 0 and 3
			if (resolve_taken) begin
				if (res_count != frontend_pkg::counter_max)
					counters[resolve_tag] <= res_count + 1'b1;
			end else begin
				if (res_count != '0)
					counters[resolve_tag] <= res_count - 1'b1;
			end
		end
	end

	// decoder never flags a word as both branch and jump
	branch_jump_excl: assert property (
		@(posedge clock) disable iff (reset)
		!(is_branch && is_jump)
	);

endmodule

/* dispatch_stage.sv */
`timescale 1ns/1ps

module dispatch_stage (
	input  logic                                   clock,
	input  logic                                   reset,
	input  logic                                   stall,
	input  logic [frontend_pkg::line_width-1:0]    icache_data,
	input  logic                                   icache_valid,
	input  logic                                   squash,
	input  logic [rv_isa_pkg::xlen-1:0]            squash_target,
	input  logic                                   resolve_valid,
	input  logic                                   resolve_is_branch,
	input  logic                                   resolve_taken,
	input  logic [frontend_pkg::bht_idx_width-1:0] resolve_tag,
	output logic [rv_isa_pkg::xlen-1:0]            imem_addr,
	output logic                                   dispatch_valid,
	output logic [rv_isa_pkg::xlen-1:0]            dispatch_pc,
	output logic [rv_isa_pkg::xlen-1:0]            dispatch_npc,
	output logic [31:0]                            dispatch_inst,
	output frontend_pkg::opa_sel_e                 opa_select,
	output frontend_pkg::opb_sel_e                 opb_select,
	output frontend_pkg::alu_func_e                alu_func,
	output logic [rv_isa_pkg::reg_idx_width-1:0]   dest_reg_idx,
	output logic                                   rd_mem,
	output logic                                   wr_mem,
	output logic                                   cond_branch,
	output logic                                   uncond_branch,
	output logic                                   mult_op,
	output logic                                   halt,
	output logic                                   illegal,
	output logic                                   rs1_req,
	output logic [rv_isa_pkg::reg_idx_width-1:0]   rs1_idx,
	output logic                                   rs2_req,
	output logic [rv_isa_pkg::reg_idx_width-1:0]   rs2_idx,
	output logic                                   predict_taken,
	output logic [rv_isa_pkg::xlen-1:0]            predict_target,
	output logic [frontend_pkg::bht_idx_width-1:0] dirp_tag
);

	logic [rv_isa_pkg::xlen-1:0] pc_reg;
	logic [rv_isa_pkg::xlen-1:0] next_pc;
	logic                        fetch_ok;
	logic                        valid_inst;
	frontend_pkg::dest_sel_e     dest_select;
	rv_isa_pkg::rv_opcode_e      opcode;

	////////////////////////////////////////
	// fetch
	////////////////////////////////////////

	// line aligned address, pc bit 2 picks the half
	assign imem_addr     = {pc_reg[rv_isa_pkg::xlen-1:3], 3'b000};
	assign dispatch_inst = pc_reg[2] ? icache_data[rv_isa_pkg::xlen +: 32] : icache_data[31:0];

	assign dispatch_pc  = pc_reg;
	assign dispatch_npc = pc_reg + 32'd4;

	// decoder sees a bubble while stalled or waiting on the cache
	assign fetch_ok       = !stall && icache_valid;
	assign dispatch_valid = valid_inst;

	assign opcode = rv_isa_pkg::rv_opcode_e'(dispatch_inst[rv_isa_pkg::opcode_width-1:0]);

	instr_decoder decoder_i (
		.valid         (fetch_ok),
		.inst          (dispatch_inst),
		.opa_select    (opa_select),
		.opb_select    (opb_select),
		.alu_func      (alu_func),
		.dest_select   (dest_select),
		.rd_mem        (rd_mem),
		.wr_mem        (wr_mem),
		.cond_branch   (cond_branch),
		.uncond_branch (uncond_branch),
		.mult_op       (mult_op),
		.halt          (halt),
		.illegal       (illegal),
		.valid_inst    (valid_inst)
	);

	// jalr is uncond too but only jal gets a target
	branch_predictor predictor_i (
		.clock             (clock),
		.reset             (reset),
		.pc                (pc_reg),
		.inst              (dispatch_inst),
		.is_branch         (cond_branch),
		.is_jump           (uncond_branch && opcode == rv_isa_pkg::op_jal),
		.resolve_valid     (resolve_valid),
		.resolve_is_branch (resolve_is_branch),
		.resolve_taken     (resolve_taken),
		.resolve_tag       (resolve_tag),
		.predict_taken     (predict_taken),
		.predict_target    (predict_target),
		.dirp_tag          (dirp_tag)
	);

	////////////////////////////////////////
	// register requests
	////////////////////////////////////////

	always_comb begin
		case (dest_select)
			frontend_pkg::dest_rd: dest_reg_idx = dispatch_inst[rv_isa_pkg::rd_lsb +: 5];
			default:               dest_reg_idx = rv_isa_pkg::zero_reg;
		endcase

		// rs1 unused by lui auipc jal
		rs1_req = !(opcode inside {rv_isa_pkg::op_lui, rv_isa_pkg::op_auipc, rv_isa_pkg::op_jal});
		rs1_idx = rs1_req ? dispatch_inst[rv_isa_pkg::rs1_lsb +: 5] : rv_isa_pkg::zero_reg;

		rs2_req = opcode inside {rv_isa_pkg::op_branch, rv_isa_pkg::op_store, rv_isa_pkg::op_reg};
		rs2_idx = rs2_req ? dispatch_inst[rv_isa_pkg::rs2_lsb +: 5] : rv_isa_pkg::zero_reg;
	end

	////////////////////////////////////////
	// pc register
	////////////////////////////////////////

	// squash wins over the prediction and over stall
	assign next_pc = squash ? squash_target : predict_target;

	always_ff @(posedge clock) begin
		if (reset)
			pc_reg <= '0;
		else if (dispatch_valid || squash)
			pc_reg <= next_pc;
	end

	// redirect lands one edge after squash
	squash_redirects: assert property (
		@(posedge clock) disable iff (reset)
		squash |=> (pc_reg == $past(squash_target))
	);

endmodule

/* flist.f */
rv_isa_pkg.sv
frontend_pkg.sv
instr_decoder.sv
branch_predictor.sv
dispatch_stage.sv
tb_dispatch_stage.sv

/* frontend_pkg.sv */
package frontend_pkg;

	////////////////////////////////////////
	// micro-op encodings
	////////////////////////////////////////

	// alu operation sent down with the micro-op
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_slt,
		alu_sltu,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_sra
	} alu_func_e;

	// operand a source
	typedef enum logic [1:0] {
		opa_is_rs1,
		opa_is_pc,
		opa_is_zero
	} opa_sel_e;

	// operand b source, the immediate type rides along here
	typedef enum logic [2:0] {
		opb_is_rs2,
		opb_is_i_imm,
		opb_is_s_imm,
		opb_is_b_imm,
		opb_is_u_imm,
		opb_is_j_imm
	} opb_sel_e;

	typedef enum logic {
		dest_rd,
		dest_none
	} dest_sel_e;

	////////////////////////////////////////
	// front-end sizes
	////////////////////////////////////////

	// icache line, two instructions
	localparam int line_width = 64;

	// bimodal table
	localparam int bht_entries   = 64;
	localparam int bht_idx_width = 6;
	localparam int bht_idx_lsb   = 2;  // word aligned pc
	localparam int counter_width = 2;
	localparam logic [counter_width-1:0] counter_reset = 2'd1;  // weakly not-taken
	localparam logic [counter_width-1:0] counter_max   = 2'd3;

endpackage

/* instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
	input  logic                    valid,
	input  logic [31:0]             inst,
	output frontend_pkg::opa_sel_e  opa_select,
	output frontend_pkg::opb_sel_e  opb_select,
	output frontend_pkg::alu_func_e alu_func,
	output frontend_pkg::dest_sel_e dest_select,
	output logic                    rd_mem,
	output logic                    wr_mem,
	output logic                    cond_branch,
	output logic                    uncond_branch,
	output logic                    mult_op,
	output logic                    halt,
	output logic                    illegal,
	output logic                    valid_inst
);

	rv_isa_pkg::rv_opcode_e opcode;
	logic [2:0]             funct3;
	logic [6:0]             funct7;
	logic                   legal;

	assign opcode = rv_isa_pkg::rv_opcode_e'(inst[rv_isa_pkg::opcode_width-1:0]);
	assign funct3 = inst[rv_isa_pkg::funct3_lsb +: 3];
	assign funct7 = inst[rv_isa_pkg::funct7_lsb +: 7];

	// integer alu op from funct3, alt selects sub / sra
	function automatic frontend_pkg::alu_func_e f3_to_alu(input logic [2:0] f3, input logic alt);
		case (f3)
			rv_isa_pkg::funct3_add_sub: return alt ? frontend_pkg::alu_sub : frontend_pkg::alu_add;
			rv_isa_pkg::funct3_sll:     return frontend_pkg::alu_sll;
			rv_isa_pkg::funct3_slt:     return frontend_pkg::alu_slt;
			rv_isa_pkg::funct3_sltu:    return frontend_pkg::alu_sltu;
			rv_isa_pkg::funct3_xor:     return frontend_pkg::alu_xor;
			rv_isa_pkg::funct3_srl_sra: return alt ? frontend_pkg::alu_sra : frontend_pkg::alu_srl;
			rv_isa_pkg::funct3_or:      return frontend_pkg::alu_or;
			default:                    return frontend_pkg::alu_and;
		endcase
	endfunction

	always_comb begin
		// bubble
		opa_select    = frontend_pkg::opa_is_rs1;
		opb_select    = frontend_pkg::opb_is_rs2;
		alu_func      = frontend_pkg::alu_add;
		dest_select   = frontend_pkg::dest_none;
		rd_mem        = 1'b0;
		wr_mem        = 1'b0;
		cond_branch   = 1'b0;
		uncond_branch = 1'b0;
		mult_op       = 1'b0;
		halt          = 1'b0;
		legal         = 1'b0;

		if (valid) begin
			case (opcode)
				rv_isa_pkg::op_lui: begin
					legal       = 1'b1;
					opa_select  = frontend_pkg::opa_is_zero;
					opb_select  = frontend_pkg::opb_is_u_imm;
					dest_select = frontend_pkg::dest_rd;
				end
				rv_isa_pkg::op_auipc: begin
					legal       = 1'b1;
					opa_select  = frontend_pkg::opa_is_pc;
					opb_select  = frontend_pkg::opb_is_u_imm;
					dest_select = frontend_pkg::dest_rd;
				end
				// jumps compute the target in the alu, link goes to rd
				rv_isa_pkg::op_jal: begin
					legal         = 1'b1;
					opa_select    = frontend_pkg::opa_is_pc;
					opb_select    = frontend_pkg::opb_is_j_imm;
					dest_select   = frontend_pkg::dest_rd;
					uncond_branch = 1'b1;
				end
				rv_isa_pkg::op_jalr: begin
					legal         = (funct3 == 3'b000);
					opb_select    = frontend_pkg::opb_is_i_imm;
					dest_select   = frontend_pkg::dest_rd;
					uncond_branch = 1'b1;
				end
				// 010 and 011 are holes in the branch group
				rv_isa_pkg::op_branch: begin
					legal       = !(funct3 inside {3'b010, 3'b011});
					opa_select  = frontend_pkg::opa_is_pc;
					opb_select  = frontend_pkg::opb_is_b_imm;
					cond_branch = 1'b1;
				end
				// lb lh lw lbu lhu
				rv_isa_pkg::op_load: begin
					legal       = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
					opb_select  = frontend_pkg::opb_is_i_imm;
					dest_select = frontend_pkg::dest_rd;
					rd_mem      = 1'b1;
				end
				// sb sh sw
				rv_isa_pkg::op_store: begin
					legal      = funct3 inside {3'b000, 3'b001, 3'b010};
					opb_select = frontend_pkg::opb_is_s_imm;
					wr_mem     = 1'b1;
				end
				rv_isa_pkg::op_imm: begin
					opb_select  = frontend_pkg::opb_is_i_imm;
					dest_select = frontend_pkg::dest_rd;
					// bit 30 only means sra for the shift group, elsewhere it is imm
					alu_func = f3_to_alu(funct3,
						(funct3 == rv_isa_pkg::funct3_srl_sra) && inst[30]);
					if (funct3 == rv_isa_pkg::funct3_sll)
						legal = (funct7 == rv_isa_pkg::funct7_zero);
					else if (funct3 == rv_isa_pkg::funct3_srl_sra)
						legal = funct7 inside {rv_isa_pkg::funct7_zero, rv_isa_pkg::funct7_alt};
					else
						legal = 1'b1;
				end
				rv_isa_pkg::op_reg: begin
					dest_select = frontend_pkg::dest_rd;
					alu_func    = f3_to_alu(funct3, funct7 == rv_isa_pkg::funct7_alt);
					if (funct7 == rv_isa_pkg::funct7_mul) begin
						// multiply family, funct3 picks the variant downstream
						legal   = 1'b1;
						mult_op = 1'b1;
					end else if (funct7 == rv_isa_pkg::funct7_alt)
						legal = funct3 inside {rv_isa_pkg::funct3_add_sub, rv_isa_pkg::funct3_srl_sra};
					else
						legal = (funct7 == rv_isa_pkg::funct7_zero);
				end
				// csr and ecall fall out as illegal
				rv_isa_pkg::op_system: begin
					legal = (inst == rv_isa_pkg::inst_wfi);
					halt  = legal;
				end
				default: legal = 1'b0;
			endcase

			// an unknown word goes down as a bubble with illegal set
			if (!legal) begin
				opa_select    = frontend_pkg::opa_is_rs1;
				opb_select    = frontend_pkg::opb_is_rs2;
				alu_func      = frontend_pkg::alu_add;
				dest_select   = frontend_pkg::dest_none;
				rd_mem        = 1'b0;
				wr_mem        = 1'b0;
				cond_branch   = 1'b0;
				uncond_branch = 1'b0;
				mult_op       = 1'b0;
				halt          = 1'b0;
			end
		end

		illegal    = valid && !legal;
		valid_inst = valid && legal;
	end

	// at most one op class per word
	one_op_class: assert final (
		$onehot0({rd_mem, wr_mem, cond_branch, uncond_branch, mult_op, halt})
	);

endmodule

/* rv_isa_pkg.sv */
package rv_isa_pkg;

	////////////////////////////////////////
	// base widths
	////////////////////////////////////////

	// data and address width of the core
	localparam int xlen = 32;

	// register index width, x0..x31
	localparam int reg_idx_width = 5;

	// x0 reads as zero, used as "no destination"
	localparam logic [reg_idx_width-1:0] zero_reg = 5'd0;

	localparam int opcode_width = 7;

	////////////////////////////////////////
	// instruction field positions
	////////////////////////////////////////

	localparam int rd_lsb     = 7;
	localparam int funct3_lsb = 12;
	localparam int rs1_lsb    = 15;
	localparam int rs2_lsb    = 20;
	localparam int funct7_lsb = 25;

	////////////////////////////////////////
	// major opcodes, bits 6..0
	////////////////////////////////////////

	typedef enum logic [opcode_width-1:0] {
		op_lui    = 7'b0110111,
		op_auipc  = 7'b0010111,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111,
		op_branch = 7'b1100011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_imm    = 7'b0010011,
		op_reg    = 7'b0110011,
		op_system = 7'b1110011
	} rv_opcode_e;

	// funct3 of the integer alu group, shared by op_imm and op_reg
	localparam logic [2:0] funct3_add_sub = 3'b000;
	localparam logic [2:0] funct3_sll     = 3'b001;
	localparam logic [2:0] funct3_slt     = 3'b010;
	localparam logic [2:0] funct3_sltu    = 3'b011;
	localparam logic [2:0] funct3_xor     = 3'b100;
	localparam logic [2:0] funct3_srl_sra = 3'b101;
	localparam logic [2:0] funct3_or      = 3'b110;
	localparam logic [2:0] funct3_and     = 3'b111;

	// funct7 variants
	localparam logic [6:0] funct7_zero = 7'b0000000;
	localparam logic [6:0] funct7_alt  = 7'b0100000;  // sub, sra
	localparam logic [6:0] funct7_mul  = 7'b0000001;  // M extension

	// wfi, the only system word the front end accepts (treated as halt)
	localparam logic [31:0] inst_wfi = 32'h1050_0073;

endpackage

/* tb_dispatch_stage.sv */
`timescale 1ns/1ps

module tb_dispatch_stage;

	localparam int num_tests   = 16;
	localparam int cycle_limit = num_tests * 8 + 50;

	// dut inputs
	logic                                   clock;
	logic                                   reset;
	logic                                   stall;
	logic [frontend_pkg::line_width-1:0]    icache_data;
	logic                                   icache_valid;
	logic                                   squash;
	logic [31:0]                            squash_target;
	logic                                   resolve_valid;
	logic                                   resolve_is_branch;
	logic                                   resolve_taken;
	logic [frontend_pkg::bht_idx_width-1:0] resolve_tag;

	// dut outputs
	logic [31:0]                            imem_addr;
	logic                                   dispatch_valid;
	logic [31:0]                            dispatch_pc;
	logic [31:0]                            dispatch_npc;
	logic [31:0]                            dispatch_inst;
	frontend_pkg::opa_sel_e                 opa_select;
	frontend_pkg::opb_sel_e                 opb_select;
	frontend_pkg::alu_func_e                alu_func;
	logic [4:0]                             dest_reg_idx;
	logic                                   rd_mem;
	logic                                   wr_mem;
	logic                                   cond_branch;
	logic                                   uncond_branch;
	logic                                   mult_op;
	logic                                   halt;
	logic                                   illegal;
	logic                                   rs1_req;
	logic [4:0]                             rs1_idx;
	logic                                   rs2_req;
	logic [4:0]                             rs2_idx;
	logic                                   predict_taken;
	logic [31:0]                            predict_target;
	logic [frontend_pkg::bht_idx_width-1:0] dirp_tag;

	// program table, entry i sits at pc 4*i
	// rs fields are {req, idx}, flags are {rd_mem, wr_mem, cond, uncond, mult, halt}
	string                   t_name  [num_tests];
	logic [31:0]             t_inst  [num_tests];
	frontend_pkg::alu_func_e t_alu   [num_tests];
	frontend_pkg::opa_sel_e  t_opa   [num_tests];
	frontend_pkg::opb_sel_e  t_opb   [num_tests];
	logic [4:0]              t_dest  [num_tests];
	logic [5:0]              t_rs1   [num_tests];
	logic [5:0]              t_rs2   [num_tests];
	logic [5:0]              t_flags [num_tests];
	logic                    t_ill   [num_tests];
	logic                    t_taken [num_tests];
	logic [31:0]             t_npc   [num_tests];

	logic [63:0] mem [32];
	logic [31:0] rng_state;
	string       test_name;
	int          n_entries = 0;
	int          test_errors;
	int          errors;
	int          tests_run;
	int          tests_failed;
	int          cycle_count = 0;

	dispatch_stage dut_i (.*);

	// icache model, answers in the same cycle
	assign icache_data = mem[imem_addr[7:3]];

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// run limit
	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic add_entry(input string name, input logic [31:0] inst,
			input frontend_pkg::alu_func_e alu, input frontend_pkg::opa_sel_e opa,
			input frontend_pkg::opb_sel_e opb, input logic [4:0] dest, input logic [5:0] rs1,
			input logic [5:0] rs2, input logic [5:0] flags, input logic ill,
			input logic taken, input logic [31:0] npc);
		t_name[n_entries]  = name;
		t_inst[n_entries]  = inst;
		t_alu[n_entries]   = alu;
		t_opa[n_entries]   = opa;
		t_opb[n_entries]   = opb;
		t_dest[n_entries]  = dest;
		t_rs1[n_entries]   = rs1;
		t_rs2[n_entries]   = rs2;
		t_flags[n_entries] = flags;
		t_ill[n_entries]   = ill;
		t_taken[n_entries] = taken;
		t_npc[n_entries]   = npc;
		n_entries++;
	endtask

	task automatic check_value(input string field, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s %s: expected %h, actual %h", test_name, field, expected, actual);
			test_errors++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		tests_run++;
		errors += test_errors;
		if (test_errors == 0)
			$display("test %-26s ok", test_name);
		else begin
			tests_failed++;
			$display("test %-26s %0d errors", test_name, test_errors);
		end
	endtask

	// random stall or cache miss cycles, at most 3 in a row
	task automatic back_pressure();
		int          run;
		logic [31:0] held;
		run = 0;
		rng_state = xorshift32(rng_state);
		while (rng_state[1:0] == 2'b00 && run < 3) begin
			@(negedge clock);
			squash       = 1'b0;
			stall        = rng_state[2];
			icache_valid = rng_state[2] ? rng_state[3] : 1'b0;
			held         = dispatch_pc;
			#1;
			check_value("held dispatch_valid", 32'd0, dispatch_valid);
			@(posedge clock);
			#1;
			check_value("held dispatch_pc", held, dispatch_pc);
			run++;
			rng_state = xorshift32(rng_state);
		end
	endtask

	// squash while stalled, pc checked after the edge
	task automatic redirect(input logic [31:0] target);
		@(negedge clock);
		stall         = 1'b1;
		squash        = 1'b1;
		squash_target = target;
		@(posedge clock);
		#1;
		check_value("squash dispatch_pc", target, dispatch_pc);
	endtask

	task automatic resolve_branch(input logic taken, input logic [5:0] tag);
		@(negedge clock);
		squash            = 1'b0;
		resolve_valid     = 1'b1;
		resolve_is_branch = 1'b1;
		resolve_taken     = taken;
		resolve_tag       = tag;
	endtask

	task automatic load_table();
		add_entry("addi", 32'h00500093, frontend_pkg::alu_add, frontend_pkg::opa_is_rs1,
			frontend_pkg::opb_is_i_imm, 5'd1, 6'h20, 6'h00, 6'b000000, 1'b0, 1'b0, 32'd4);
		add_entry("add", 32'h002081B3, frontend_pkg::alu_add, frontend_pkg::opa_is_rs1,
			frontend_pkg::opb_is_rs2, 5'd3, 6'h21, 6'h22, 6'b000000, 1'b0, 1'b0, 32'd8);
		add_entry("sub", 32'h40118233, frontend_pkg::alu_sub, frontend_pkg::opa_is_rs1,
			frontend_pkg::opb_is_rs2, 5'd4, 6'h23, 6'h21, 6'b000000, 1'b0, 1'b0, 32'd12);
		add_entry("sra", 32'h402252B3, frontend_pkg::alu_sra, frontend_pkg::opa_is_rs1,
			frontend_pkg::opb_is_rs2, 5'd5, 6'h24, 6'h22, 6'b000000, 1'b0, 1'b0, 32'd16);
		add_entry("lw", 32'h0080A303, frontend_pkg::alu_add, frontend_pkg::opa_is_rs1,
			frontend_pkg::opb_is_i_imm, 5'd6, 6'h21, 6'h00, 6'b100000, 1'b0, 1'b0, 32'd20);
		add_entry("sw", 32'h0060A623, frontend_pkg::alu_add, frontend_pkg::opa_is_rs1,
			frontend_pkg::opb_is_s_imm, 5'd0, 6'h21, 6'h26, 6'b010000, 1'b0, 1'b0, 32'd24);
		add_entry("lui", 32'h123453B7, frontend_pkg::alu_add, frontend_pkg::opa_is_zero,
			frontend_pkg::opb_is_u_imm, 5'd7, 6'h00, 6'h00, 6'b000000, 1'b0, 1'b0, 32'd28);
		add_entry("auipc", 32'h00001417, frontend_pkg::alu_add, frontend_pkg::opa_is_pc,
			frontend_pkg::opb_is_u_imm, 5'd8, 6'h00, 6'h00, 6'b000000, 1'b0, 1'b0, 32'd32);
		add_entry("mul", 32'h022084B3, frontend_pkg::alu_add, frontend_pkg::opa_is_rs1,
			frontend_pkg::opb_is_rs2, 5'd9, 6'h21, 6'h22, 6'b000010, 1'b0, 1'b0, 32'd36);
		// jal +4, taken with target pc+4
		add_entry("jal", 32'h004000EF, frontend_pkg::alu_add, frontend_pkg::opa_is_pc,
			frontend_pkg::opb_is_j_imm, 5'd1, 6'h00, 6'h00, 6'b000100, 1'b0, 1'b1, 32'd40);
		// beq +16, counter at reset value so not taken
		add_entry("beq", 32'h00208863, frontend_pkg::alu_add, frontend_pkg::opa_is_pc,
			frontend_pkg::opb_is_b_imm, 5'd0, 6'h21, 6'h22, 6'b001000, 1'b0, 1'b0, 32'd44);
		// csr word, pc holds until squash to 48
		add_entry("csrrw", 32'h30001073, frontend_pkg::alu_add, frontend_pkg::opa_is_rs1,
			frontend_pkg::opb_is_rs2, 5'd0, 6'h20, 6'h00, 6'b000000, 1'b1, 1'b0, 32'd48);
		add_entry("xori", 32'hFFF0C513, frontend_pkg::alu_xor, frontend_pkg::opa_is_rs1,
			frontend_pkg::opb_is_i_imm, 5'd10, 6'h21, 6'h00, 6'b000000, 1'b0, 1'b0, 32'd52);
		add_entry("srai", 32'h4030D593, frontend_pkg::alu_sra, frontend_pkg::opa_is_rs1,
			frontend_pkg::opb_is_i_imm, 5'd11, 6'h21, 6'h00, 6'b000000, 1'b0, 1'b0, 32'd56);
		add_entry("wfi", 32'h10500073, frontend_pkg::alu_add, frontend_pkg::opa_is_rs1,
			frontend_pkg::opb_is_rs2, 5'd0, 6'h20, 6'h00, 6'b000001, 1'b0, 1'b0, 32'd60);
		// jalr not predicted, falls to pc+4
		add_entry("jalr", 32'h00008067, frontend_pkg::alu_add, frontend_pkg::opa_is_rs1,
			frontend_pkg::opb_is_i_imm, 5'd0, 6'h21, 6'h00, 6'b000100, 1'b0, 1'b0, 32'd64);
	endtask

	////////////////////////////////////////
	// one table entry
	////////////////////////////////////////

	task automatic run_entry(input int i);
		logic [31:0] pc;
		pc = 32'(i * 4);
		begin_test(t_name[i]);
		back_pressure();
		@(negedge clock);
		stall        = 1'b0;
		icache_valid = 1'b1;
		squash       = 1'b0;
		#1;
		check_value("dispatch_pc", pc, dispatch_pc);
		check_value("imem_addr", {pc[31:3], 3'b000}, imem_addr);
		check_value("dispatch_npc", pc + 32'd4, dispatch_npc);
		check_value("dispatch_inst", t_inst[i], dispatch_inst);
		check_value("dispatch_valid", 32'(!t_ill[i]), dispatch_valid);
		check_value("alu_func", 32'(t_alu[i]), 32'(alu_func));
		check_value("opa_select", 32'(t_opa[i]), 32'(opa_select));
		check_value("opb_select", 32'(t_opb[i]), 32'(opb_select));
		check_value("dest_reg_idx", 32'(t_dest[i]), dest_reg_idx);
		check_value("rs1", 32'(t_rs1[i]), {rs1_req, rs1_idx});
		check_value("rs2", 32'(t_rs2[i]), {rs2_req, rs2_idx});
		check_value("flags", 32'(t_flags[i]),
			{rd_mem, wr_mem, cond_branch, uncond_branch, mult_op, halt});
		check_value("illegal", 32'(t_ill[i]), illegal);
		check_value("predict_taken", 32'(t_taken[i]), predict_taken);
		check_value("predict_target", t_npc[i], predict_target);
		if (t_ill[i]) begin
			// illegal word is not dispatched
			@(posedge clock);
			#1;
			check_value("illegal held pc", pc, dispatch_pc);
			@(negedge clock);
			stall         = 1'b1;
			squash        = 1'b1;
			squash_target = t_npc[i];
		end
		@(posedge clock);
		#1;
		check_value("next pc", t_npc[i], dispatch_pc);
		end_test();
	endtask

	////////////////////////////////////////
	// squash and predictor training
	////////////////////////////////////////

	task automatic run_predict();
		logic [5:0] tag;
		begin_test("squash_while_stalled");
		redirect(32'd40);
		// counter index is pc bits 7..2
		check_value("dirp_tag", 32'd10, dirp_tag);
		end_test();

		begin_test("beq_trained_taken");
		tag = dirp_tag;
		repeat (2) resolve_branch(1'b1, tag);
		@(negedge clock);
		resolve_valid = 1'b0;
		stall         = 1'b0;
		#1;
		check_value("predict_taken", 32'd1, predict_taken);
		check_value("predict_target", 32'd56, predict_target);
		@(posedge clock);
		#1;
		check_value("next pc", 32'd56, dispatch_pc);
		end_test();

		begin_test("beq_trained_not_taken");
		redirect(32'd40);
		repeat (3) resolve_branch(1'b0, tag);
		@(negedge clock);
		resolve_valid = 1'b0;
		stall         = 1'b0;
		#1;
		check_value("predict_taken", 32'd0, predict_taken);
		check_value("predict_target", 32'd44, predict_target);
		@(posedge clock);
		#1;
		check_value("next pc", 32'd44, dispatch_pc);
		end_test();
	endtask

	initial begin
		reset             = 1'b1;
		stall             = 1'b0;
		icache_valid      = 1'b0;
		squash            = 1'b0;
		squash_target     = '0;
		resolve_valid     = 1'b0;
		resolve_is_branch = 1'b0;
		resolve_taken     = 1'b0;
		resolve_tag       = '0;
		rng_state         = 32'd56894;
		errors            = 0;
		tests_run         = 0;
		tests_failed      = 0;
		load_table();
		// filler tagged with its byte address, program on top
		for (int j = 0; j < 32; j++)
			mem[j] = {32'hdead_0000 | 32'(j * 8 + 4), 32'hdead_0000 | 32'(j * 8)};
		for (int i = 0; i < num_tests; i++)
			mem[i / 2][(i % 2) * 32 +: 32] = t_inst[i];

		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		for (int i = 0; i < num_tests; i++)
			run_entry(i);
		run_predict();

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule
